//--- rtl/simt_mem_cfg.svh
`ifndef SIMT_MEM_CFG_SVH
`define SIMT_MEM_CFG_SVH

// ==========================================================
// Memory unit configuration
// ==========================================================

// Threads per warp and also the number of words in one block
`define SIMT_THREADS 8

// Width of data words and of addresses
`define SIMT_WORD_W 32

// Byte offset bits inside a 32-byte block
`define SIMT_BLK_OFS_W 5

// The RAM holds 2**6 blocks and higher block bits wrap
`define SIMT_RAM_IDX_W 6

`endif

//--- rtl/simt_mem_pkg.sv
`include "simt_mem_cfg.svh"

package simt_mem_pkg;

	typedef logic [`SIMT_WORD_W-1:0] word_t;
	typedef logic [`SIMT_THREADS-1:0] lane_mask_t;
	typedef logic [`SIMT_WORD_W-`SIMT_BLK_OFS_W-1:0] blk_addr_t;
	typedef logic [`SIMT_BLK_OFS_W-3:0] word_sel_t;
	typedef logic [2:0] warp_id_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic signed [15:0] offset_t;

	// One warp-wide request as it arrives at the unit
	typedef struct packed {
		logic                     is_write;
		warp_id_t                 warp_id;
		reg_addr_t                reg_addr;
		lane_mask_t               mask;
		word_t [`SIMT_THREADS-1:0] base;
		offset_t                  offset;
		word_t [`SIMT_THREADS-1:0] wdata;
	} mem_req_t;

	// Registered request with effective addresses already formed
	typedef struct packed {
		logic                     is_write;
		warp_id_t                 warp_id;
		reg_addr_t                reg_addr;
		lane_mask_t               mask;
		word_t [`SIMT_THREADS-1:0] addr;
		word_t [`SIMT_THREADS-1:0] wdata;
	} lane_req_t;

	// One block access and the threads it serves
	typedef struct packed {
		logic       is_write;
		blk_addr_t  blk_addr;
		lane_mask_t serve;
	} blk_access_t;

	typedef struct packed {
		warp_id_t                 warp_id;
		reg_addr_t                reg_addr;
		logic                     is_write;
		word_t [`SIMT_THREADS-1:0] data;
	} mem_resp_t;

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT,
		RESP
	} ctrl_state_e;

endpackage

//--- rtl/mem_addr_gen.sv
`timescale 1ns/1ps
`include "simt_mem_cfg.svh"

module mem_addr_gen (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  logic                    req_valid_i,
	input  simt_mem_pkg::mem_req_t  req_i,
	output logic                    lane_valid_o,
	output simt_mem_pkg::lane_req_t lane_o
);
	import simt_mem_pkg::*;

	localparam int OFS_W = $bits(offset_t);

	word_t                     ofs_ext;
	word_t [`SIMT_THREADS-1:0] eff_addr;

	// ==========================================================
	// Effective address per thread
	// ==========================================================

	assign ofs_ext = {{(`SIMT_WORD_W-OFS_W){req_i.offset[OFS_W-1]}}, req_i.offset};

	always_comb
	begin
		for (int i = 0; i < `SIMT_THREADS; i++)
		begin
			eff_addr[i] = req_i.base[i] + ofs_ext;
		end
	end

	// ==========================================================
	// Request register
	// ==========================================================

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			lane_valid_o <= 1'b0;
		end
		else
		begin
			lane_valid_o <= req_valid_i;
		end
	end

	// Payload only changes when a request is strobed in
	always_ff @(posedge clk)
	begin
		if (req_valid_i)
		begin
			lane_o.is_write <= req_i.is_write;
			lane_o.warp_id  <= req_i.warp_id;
			lane_o.reg_addr <= req_i.reg_addr;
			lane_o.mask     <= req_i.mask;
			lane_o.addr     <= eff_addr;
			lane_o.wdata    <= req_i.wdata;
		end
	end

endmodule

//--- rtl/mem_coalesce_ctrl.sv
`timescale 1ns/1ps
`include "simt_mem_cfg.svh"

module mem_coalesce_ctrl (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic                      req_valid_i,
	input  logic                      lane_valid_i,
	input  simt_mem_pkg::lane_req_t   lane_i,
	output logic                      acc_valid_o,
	output simt_mem_pkg::blk_access_t acc_o,
	output logic                      resp_valid_o,
	output logic                      busy_o
);
	import simt_mem_pkg::*;

	localparam int TID_W = $clog2(`SIMT_THREADS);

	ctrl_state_e      state_q;
	lane_mask_t       pending_q;
	lane_mask_t       serve_mask;
	lane_mask_t       remain;
	logic [TID_W-1:0] lead;
	blk_addr_t        lead_blk;
	logic             busy_q;

	// ==========================================================
	// Block selection
	// ==========================================================

	// Lowest pending thread picks the block for this pass
	always_comb
	begin
		lead = '0;
		for (int i = `SIMT_THREADS - 1; i >= 0; i--)
		begin
			if (pending_q[i])
				lead = TID_W'(i);
		end
	end

	assign lead_blk = lane_i.addr[lead][`SIMT_WORD_W-1:`SIMT_BLK_OFS_W];

	always_comb
	begin
		for (int i = 0; i < `SIMT_THREADS; i++)
		begin
			serve_mask[i] = pending_q[i] &&
				(lane_i.addr[i][`SIMT_WORD_W-1:`SIMT_BLK_OFS_W] == lead_blk);
		end
	end

	assign remain = pending_q & ~serve_mask;

	assign acc_valid_o = (state_q == ISSUE);
	assign acc_o = '{is_write: lane_i.is_write, blk_addr: lead_blk, serve: serve_mask};

	// ==========================================================
	// State machine
	// ==========================================================

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			state_q   <= IDLE;
			pending_q <= '0;
			busy_q    <= 1'b0;
		end
		else
		begin
			case (state_q)
				IDLE:
				begin
					if (req_valid_i && !busy_q)
						busy_q <= 1'b1;
					if (lane_valid_i && busy_q)
					begin
						pending_q <= lane_i.mask;
						state_q   <= (lane_i.mask == '0) ? RESP : ISSUE;
					end
				end
				ISSUE:
				begin
					pending_q <= remain;
					if (!lane_i.is_write)
						state_q <= WAIT;
					else if (remain == '0)
						state_q <= RESP;
				end
				// The read data is captured during this cycle
				WAIT:
				begin
					state_q <= (pending_q == '0) ? RESP : ISSUE;
				end
				RESP:
				begin
					busy_q  <= 1'b0;
					state_q <= IDLE;
				end
				default:
				begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	assign resp_valid_o = (state_q == RESP);
	assign busy_o = busy_q;

endmodule

//--- rtl/mem_block_ram.sv
`timescale 1ns/1ps
`include "simt_mem_cfg.svh"

module mem_block_ram (
	input  logic                                    clk,
	input  logic                                    rd_i,
	input  simt_mem_pkg::lane_mask_t                we_i,
	input  logic [`SIMT_RAM_IDX_W-1:0]              idx_i,
	input  simt_mem_pkg::word_t [`SIMT_THREADS-1:0] wdata_i,
	output simt_mem_pkg::word_t [`SIMT_THREADS-1:0] rdata_o
);
	import simt_mem_pkg::*;

	localparam int BLOCKS = 1 << `SIMT_RAM_IDX_W;

	word_t mem_q [BLOCKS][`SIMT_THREADS];

	// ==========================================================
	// Per-word writes
	// ==========================================================

	always_ff @(posedge clk)
	begin
		for (int w = 0; w < `SIMT_THREADS; w++)
		begin
			if (we_i[w])
				mem_q[idx_i][w] <= wdata_i[w];
		end
	end

	// Whole block comes back one cycle after the read strobe
	always_ff @(posedge clk)
	begin
		if (rd_i)
		begin
			for (int w = 0; w < `SIMT_THREADS; w++)
			begin
				rdata_o[w] <= mem_q[idx_i][w];
			end
		end
	end

endmodule

//--- rtl/mem_lane_gather.sv
`timescale 1ns/1ps
`include "simt_mem_cfg.svh"

module mem_lane_gather (
	input  logic                                    clk,
	input  logic                                    rst_n_i,
	input  simt_mem_pkg::lane_req_t                 lane_i,
	input  logic                                    acc_valid_i,
	input  simt_mem_pkg::blk_access_t               acc_i,
	output logic                                    ram_rd_o,
	output simt_mem_pkg::lane_mask_t                ram_we_o,
	output logic [`SIMT_RAM_IDX_W-1:0]              ram_idx_o,
	output simt_mem_pkg::word_t [`SIMT_THREADS-1:0] ram_wdata_o,
	input  simt_mem_pkg::word_t [`SIMT_THREADS-1:0] ram_rdata_i,
	output simt_mem_pkg::mem_resp_t                 resp_o
);
	import simt_mem_pkg::*;

	word_sel_t [`SIMT_THREADS-1:0] lane_sel;
	lane_mask_t                    wr_en;
	lane_mask_t                    rd_mask_q;
	word_t [`SIMT_THREADS-1:0]     result_q;

	always_comb
	begin
		for (int i = 0; i < `SIMT_THREADS; i++)
		begin
			lane_sel[i] = lane_i.addr[i][`SIMT_BLK_OFS_W-1:2];
		end
	end

	// ==========================================================
	// Store scatter
	// ==========================================================

	// Ascending order lets the highest served thread win a shared word
	always_comb
	begin
		ram_wdata_o = '0;
		wr_en       = '0;
		for (int i = 0; i < `SIMT_THREADS; i++)
		begin
			if (acc_i.serve[i])
			begin
				ram_wdata_o[lane_sel[i]] = lane_i.wdata[i];
				wr_en[lane_sel[i]]       = 1'b1;
			end
		end
	end

	assign ram_rd_o  = acc_valid_i && !acc_i.is_write;
	assign ram_we_o  = (acc_valid_i && acc_i.is_write) ? wr_en : '0;
	assign ram_idx_o = acc_i.blk_addr[`SIMT_RAM_IDX_W-1:0];

	// ==========================================================
	// Load gather
	// ==========================================================

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			rd_mask_q <= '0;
			result_q  <= '0;
		end
		else
		begin
			rd_mask_q <= ram_rd_o ? acc_i.serve : '0;
			if (rd_mask_q != '0)
			begin
				for (int i = 0; i < `SIMT_THREADS; i++)
				begin
					if (rd_mask_q[i])
						result_q[i] <= ram_rdata_i[lane_sel[i]];
				end
			end
			// Nothing in flight means the response has gone out, so start the next one clean
			else if (!acc_valid_i)
			begin
				result_q <= '0;
			end
		end
	end

	assign resp_o = '{warp_id: lane_i.warp_id, reg_addr: lane_i.reg_addr,
		is_write: lane_i.is_write, data: result_q};

endmodule

//--- rtl/simt_mem_unit.sv
`timescale 1ns/1ps
`include "simt_mem_cfg.svh"

module simt_mem_unit (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  logic                    req_valid_i,
	input  simt_mem_pkg::mem_req_t  req_i,
	output logic                    resp_valid_o,
	output simt_mem_pkg::mem_resp_t resp_o,
	output logic                    busy_o
);
	import simt_mem_pkg::*;

	logic                          lane_valid;
	lane_req_t                     lane;
	logic                          acc_valid;
	blk_access_t                   acc;
	logic                          ram_rd;
	lane_mask_t                    ram_we;
	logic [`SIMT_RAM_IDX_W-1:0]    ram_idx;
	word_t [`SIMT_THREADS-1:0]     ram_wdata;
	word_t [`SIMT_THREADS-1:0]     ram_rdata;

	mem_addr_gen u_addr_gen (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.req_valid_i  (req_valid_i),
		.req_i        (req_i),
		.lane_valid_o (lane_valid),
		.lane_o       (lane)
	);

	mem_coalesce_ctrl u_ctrl (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.req_valid_i  (req_valid_i),
		.lane_valid_i (lane_valid),
		.lane_i       (lane),
		.acc_valid_o  (acc_valid),
		.acc_o        (acc),
		.resp_valid_o (resp_valid_o),
		.busy_o       (busy_o)
	);

	mem_lane_gather u_gather (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.lane_i      (lane),
		.acc_valid_i (acc_valid),
		.acc_i       (acc),
		.ram_rd_o    (ram_rd),
		.ram_we_o    (ram_we),
		.ram_idx_o   (ram_idx),
		.ram_wdata_o (ram_wdata),
		.ram_rdata_i (ram_rdata),
		.resp_o      (resp_o)
	);

	mem_block_ram u_ram (
		.clk     (clk),
		.rd_i    (ram_rd),
		.we_i    (ram_we),
		.idx_i   (ram_idx),
		.wdata_i (ram_wdata),
		.rdata_o (ram_rdata)
	);

endmodule

//--- tests/simt_mem_assertions.sv
`timescale 1ns/1ps

module simt_mem_assertions (
	input logic clk,
	input logic rst_n_i,
	input logic resp_valid_i,
	input logic busy_i,
	input logic acc_valid_i
);

	reset_clears_a: assert property (@(posedge clk) !rst_n_i |=> (!busy_i && !resp_valid_i))
		else $error("busy_o or resp_valid_o high after reset");

	resp_one_cycle_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		resp_valid_i |=> !resp_valid_i)
		else $error("resp_valid_o held for more than one cycle");

	// The response cycle is the last busy cycle
	resp_while_busy_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		resp_valid_i |-> busy_i)
		else $error("resp_valid_o high while busy_o is low");

	busy_drops_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		resp_valid_i |=> !busy_i)
		else $error("busy_o still high after the response");

	busy_fall_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		$fell(busy_i) |-> $past(resp_valid_i))
		else $error("busy_o fell without a response");

	no_idle_access_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		acc_valid_i |-> busy_i)
		else $error("block access issued while the unit is idle");

endmodule

bind simt_mem_unit simt_mem_assertions u_assertions (
	.clk          (clk),
	.rst_n_i      (rst_n_i),
	.resp_valid_i (resp_valid_o),
	.busy_i       (busy_o),
	.acc_valid_i  (acc_valid)
);

//--- tests/simt_mem_tb.sv
`timescale 1ns/1ps
`include "simt_mem_cfg.svh"

module simt_mem_tb;
	import simt_mem_pkg::*;

	localparam int RESP_TIMEOUT = 64;

	logic      clk;
	logic      rst_n;
	logic      req_valid;
	mem_req_t  req;
	logic      resp_valid;
	mem_resp_t resp;
	logic      busy;

	// Word model keyed by the word index the RAM really decodes
	word_t model [int];
	word_t rng_state;
	int    errors;
	int    checks;
	int    tests;

	simt_mem_unit dut_i (
		.clk          (clk),
		.rst_n_i      (rst_n),
		.req_valid_i  (req_valid),
		.req_i        (req),
		.resp_valid_o (resp_valid),
		.resp_o       (resp),
		.busy_o       (busy)
	);

	always #4 clk = ~clk;

	function automatic word_t next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// Only 64 blocks exist, so bits above 10 wrap onto the same word
	function automatic int word_key(input word_t addr);
		return int'(addr[`SIMT_RAM_IDX_W+`SIMT_BLK_OFS_W-1:2]);
	endfunction

	function automatic word_t fill_word(input word_t addr);
		return (addr ^ 32'hc3a5_0f1e) * 32'h9e37_79b9;
	endfunction

	function automatic word_t thread_addr(input mem_req_t r, input int i);
		return r.base[i] + {{16{r.offset[15]}}, r.offset};
	endfunction

	// One access per distinct 32-byte block among the active threads
	function automatic int count_blocks(input mem_req_t r);
		int n;
		bit fresh;
		n = 0;
		for (int i = 0; i < `SIMT_THREADS; i++)
		begin
			fresh = r.mask[i];
			for (int j = 0; j < i; j++)
			begin
				if (r.mask[j] && ((thread_addr(r, j) >> `SIMT_BLK_OFS_W) ==
					(thread_addr(r, i) >> `SIMT_BLK_OFS_W)))
					fresh = 1'b0;
			end
			if (fresh)
				n++;
		end
		return n;
	endfunction

	function automatic mem_req_t make_req(input logic wr, input lane_mask_t mask,
		input offset_t ofs);
		mem_req_t r;
		r = '0;
		r.is_write = wr;
		r.warp_id  = warp_id_t'(next_rand());
		r.reg_addr = reg_addr_t'(next_rand());
		r.mask     = mask;
		r.offset   = ofs;
		for (int i = 0; i < `SIMT_THREADS; i++)
		begin
			r.wdata[i] = next_rand();
		end
		return r;
	endfunction

	task automatic check_value(input string name, input word_t got, input word_t exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("ERR %s got %h exp %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors == err_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - err_before);
	endtask

	// ==========================================================
	// One request, its response and the model update
	// ==========================================================

	task automatic access(input mem_req_t r, output int latency);
		word_t addr;
		word_t exp;
		bit    seen;
		@(posedge clk);
		req_valid <= 1'b1;
		req       <= r;
		@(posedge clk);
		req_valid <= 1'b0;
		seen    = 1'b0;
		latency = 0;
		while (!seen && latency < RESP_TIMEOUT)
		begin
			@(negedge clk);
			latency++;
			seen = resp_valid;
			check_value("busy_o", word_t'(busy), 32'd1);
		end
		if (!seen)
		begin
			$display("No response within %0d cycles for warp %0d", RESP_TIMEOUT, r.warp_id);
			errors++;
		end
		else
		begin
			// Loads take two cycles per block and stores one
			check_value("latency", word_t'(latency),
				word_t'(2 + count_blocks(r) * (r.is_write ? 1 : 2)));
			check_value("resp.warp_id", word_t'(resp.warp_id), word_t'(r.warp_id));
			check_value("resp.reg_addr", word_t'(resp.reg_addr), word_t'(r.reg_addr));
			check_value("resp.is_write", word_t'(resp.is_write), word_t'(r.is_write));
			for (int i = 0; i < `SIMT_THREADS; i++)
			begin
				addr = thread_addr(r, i);
				exp  = '0;
				// Ascending thread order lets the highest thread win a shared word
				if (r.is_write && r.mask[i])
					model[word_key(addr)] = r.wdata[i];
				else if (!r.is_write && r.mask[i])
					exp = model[word_key(addr)];
				check_value($sformatf("resp.data[%0d]", i), resp.data[i], exp);
			end
		end
	endtask

	// ==========================================================
	// Directed tests
	// ==========================================================

	task automatic preload_memory();
		mem_req_t r;
		int       lat;
		int       err_before;
		err_before = errors;
		for (int b = 0; b < (1 << `SIMT_RAM_IDX_W); b++)
		begin
			r = make_req(1'b1, '1, '0);
			for (int i = 0; i < `SIMT_THREADS; i++)
			begin
				r.base[i]  = word_t'(b * 32 + i * 4);
				r.wdata[i] = fill_word(r.base[i]);
			end
			access(r, lat);
		end
		report_test("preload", err_before);
	endtask

	task automatic test_store_reload();
		mem_req_t r;
		int       lat;
		int       err_before;
		err_before = errors;
		r = make_req(1'b1, '1, 16'sd8);
		for (int i = 0; i < `SIMT_THREADS; i++)
		begin
			r.base[i] = 32'h0000_0318 + i * 4;
		end
		access(r, lat);
		r.is_write = 1'b0;
		access(r, lat);
		report_test("store_reload", err_before);
	endtask

	task automatic test_scattered();
		mem_req_t r;
		int       lat;
		int       err_before;
		err_before = errors;
		for (int n = 0; n < 4; n++)
		begin
			r = make_req(1'b0, '1, (n % 2 == 1) ? 16'sd196 : -16'sd44);
			for (int i = 0; i < `SIMT_THREADS; i++)
			begin
				r.base[i] = next_rand();
			end
			access(r, lat);
		end
		report_test("scattered", err_before);
	endtask

	task automatic test_partial_masks();
		mem_req_t r;
		int       lat;
		int       err_before;
		err_before = errors;
		r = make_req(1'b0, 8'b1010_0110, '0);
		for (int i = 0; i < `SIMT_THREADS; i++)
		begin
			r.base[i] = 32'h0000_0400 + i * 36;
		end
		access(r, lat);
		r.is_write = 1'b1;
		r.mask     = 8'b0001_0001;
		access(r, lat);
		r.is_write = 1'b0;
		r.mask     = '1;
		access(r, lat);
		// An empty mask skips every access and answers on the second cycle
		r.mask = '0;
		access(r, lat);
		report_test("partial_masks", err_before);
	endtask

	task automatic test_store_conflict();
		mem_req_t r;
		int       lat;
		int       err_before;
		err_before = errors;
		r = make_req(1'b1, 8'b1101_0110, '0);
		for (int i = 0; i < `SIMT_THREADS; i++)
		begin
			r.base[i] = (i < 4) ? 32'h0000_05a4 : 32'h0000_05a8;
		end
		access(r, lat);
		r.is_write = 1'b0;
		r.mask     = '1;
		access(r, lat);
		report_test("store_conflict", err_before);
	endtask

	task automatic test_alias();
		mem_req_t r;
		int       lat;
		int       err_before;
		err_before = errors;
		r = make_req(1'b1, 8'b0000_0001, '0);
		r.base[0] = 32'h0001_0a2c;
		access(r, lat);
		r = make_req(1'b0, 8'b0000_0111, '0);
		r.base[0] = 32'h0000_0a2c;
		r.base[1] = 32'hfff0_0a2c;
		r.base[2] = 32'h0000_122c;
		access(r, lat);
		report_test("alias", err_before);
	endtask

	task automatic test_random_mix();
		mem_req_t r;
		word_t    sel;
		word_t    region;
		int       lat;
		int       err_before;
		err_before = errors;
		for (int n = 0; n < 24; n++)
		begin
			sel    = next_rand();
			region = next_rand();
			r = make_req(sel[0], lane_mask_t'(sel[15:8]), offset_t'($signed(sel[31:20])));
			for (int i = 0; i < `SIMT_THREADS; i++)
			begin
				r.base[i] = region + (next_rand() & 32'h0000_007c);
			end
			access(r, lat);
		end
		report_test("random_mix", err_before);
	endtask

	initial
	begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		req_valid = 1'b0;
		req       = '0;
		rng_state = 32'hfdcf_004c;
		errors    = 0;
		checks    = 0;
		tests     = 0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		preload_memory();
		test_store_reload();
		test_scattered();
		test_partial_masks();
		test_store_conflict();
		test_alias();
		test_random_mix();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- tb.f
+incdir+rtl
rtl/simt_mem_pkg.sv
rtl/mem_addr_gen.sv
rtl/mem_coalesce_ctrl.sv
rtl/mem_block_ram.sv
rtl/mem_lane_gather.sv
rtl/simt_mem_unit.sv
tests/simt_mem_assertions.sv
tests/simt_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the testbench with Verilator
verilator --binary --timing --assert -f tb.f --top-module simt_mem_tb -o simt_mem_sim \
	&& ./obj_dir/simt_mem_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
